// File: Makefile
# Verilator build and run of the peripheral block testbench
# any variable can be overridden, for example make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= deca_periph_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: include/deca_periph_config.svh
/*
  bus and peripheral sizes for the board peripheral block
  accesses are whole 32-bit words, so the word offset starts at bit 2
  timer halves assume DECA_DATA_W is 32
*/
`ifndef DECA_PERIPH_CONFIG_SVH
`define DECA_PERIPH_CONFIG_SVH

`define DECA_DATA_W 32
`define DECA_ADDR_W 16

// slave select field of the byte address
`define DECA_REGION_LSB 8
`define DECA_REGION_W 4

// word register offset inside one slave
`define DECA_REG_LSB 2
`define DECA_REG_W 3

`define DECA_GPIO_W 8
`define DECA_LED_W 8
// key1, sw0, sw1, also the interrupt source count
`define DECA_SWITCH_N 3
`define DECA_SYNC_STAGES 2

`endif

// File: logic/board_io.sv
/*
  key and slide switches with change interrupts, plus the LED register
  levels and pending bits update DECA_SYNC_STAGES+1 cycles after a pin edge
  no debounce, every bounce sets the pending bit again
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module board_io (
  input  logic                      wb_clk,
  input  logic                      reset_i,
  wb_slave_if.slave                 bus,
  input  logic                      key_i,
  input  logic                      sw0_i,
  input  logic                      sw1_i,
  output logic [`DECA_LED_W-1:0]    leds_o,
  output logic [`DECA_SWITCH_N-1:0] pending_o
);

  logic [`DECA_SYNC_STAGES-1:0][`DECA_SWITCH_N-1:0] sync_q;
  logic [`DECA_SWITCH_N-1:0] level_q;
  logic [`DECA_SWITCH_N-1:0] change;
  logic [`DECA_SWITCH_N-1:0] clear;
  logic                      ack_q;
  logic                      wr;

  assign wr     = bus.stb && bus.we && !ack_q;
  assign change = sync_q[`DECA_SYNC_STAGES-1] ^ level_q;

  // write 1 to clear
  assign clear = (wr && (bus.reg_adr == deca_periph_pkg::BOARD_PENDING)) ?
                 bus.wdata[`DECA_SWITCH_N-1:0] : '0;

  always_ff @(posedge wb_clk) begin
    if (reset_i) begin
      sync_q    <= '0;
      level_q   <= '0;
      pending_o <= '0;
      leds_o    <= '0;
      ack_q     <= 1'b0;
    end else begin
      sync_q[0] <= {sw1_i, sw0_i, key_i};
      for (int i = 1; i < `DECA_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      level_q <= sync_q[`DECA_SYNC_STAGES-1];
      // a fresh change beats a clear on the same edge
      pending_o <= (pending_o & ~clear) | change;
      ack_q     <= bus.stb && !ack_q;
      if (wr && (bus.reg_adr == deca_periph_pkg::BOARD_LEDS)) begin
        leds_o <= bus.wdata[`DECA_LED_W-1:0];
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (deca_periph_pkg::board_reg_e'(bus.reg_adr))
      deca_periph_pkg::BOARD_SWITCH:  bus.rdata[`DECA_SWITCH_N-1:0] = level_q;
      deca_periph_pkg::BOARD_PENDING: bus.rdata[`DECA_SWITCH_N-1:0] = pending_o;
      deca_periph_pkg::BOARD_LEDS:    bus.rdata[`DECA_LED_W-1:0]    = leds_o;
      default: ;
    endcase
  end

  assign bus.ack = ack_q;

endmodule

`default_nettype wire

// File: logic/deca_periph_pkg.sv
/*
  shared types of the peripheral block
  region values 5 to 15 are unmapped and answer with a bus error
*/
`default_nettype none

`include "deca_periph_config.svh"

package deca_periph_pkg;

  typedef logic [`DECA_DATA_W-1:0] word_t;

  typedef enum logic [`DECA_REGION_W-1:0] {
    REGION_GPIO_A = 4'd0,
    REGION_GPIO_B = 4'd1,
    REGION_BOARD  = 4'd2,
    REGION_TIMER  = 4'd3,
    REGION_ICTRL  = 4'd4
  } region_e;

  typedef enum logic [`DECA_REG_W-1:0] {
    GPIO_DATA = 3'd0,
    GPIO_DIR  = 3'd1
  } gpio_reg_e;

  typedef enum logic [`DECA_REG_W-1:0] {
    BOARD_SWITCH  = 3'd0,
    BOARD_PENDING = 3'd1,
    BOARD_LEDS    = 3'd2
  } board_reg_e;

  typedef enum logic [`DECA_REG_W-1:0] {
    MTIME_LO    = 3'd0,
    MTIME_HI    = 3'd1,
    MTIMECMP_LO = 3'd2,
    MTIMECMP_HI = 3'd3
  } timer_reg_e;

  typedef enum logic [`DECA_REG_W-1:0] {
    ICTRL_STATUS = 3'd0,
    ICTRL_ENABLE = 3'd1
  } ictrl_reg_e;

endpackage

`default_nettype wire

// File: logic/deca_periph_top.sv
/*
  board peripheral block behind one Wishbone slave port
  single clock wb_clk, synchronous active-high reset_i
  word accesses only, no byte selects, bursts or retry
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module deca_periph_top (
  input  logic                    wb_clk,
  input  logic                    reset_i,
  input  logic [`DECA_ADDR_W-1:0] wb_adr_i,
  input  logic [`DECA_DATA_W-1:0] wb_dat_i,
  input  logic                    wb_we_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  output logic [`DECA_DATA_W-1:0] wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  input  logic [`DECA_GPIO_W-1:0] gpio_a_i,
  output logic [`DECA_GPIO_W-1:0] gpio_a_o,
  output logic [`DECA_GPIO_W-1:0] gpio_a_oe_o,
  input  logic [`DECA_GPIO_W-1:0] gpio_b_i,
  output logic [`DECA_GPIO_W-1:0] gpio_b_o,
  output logic [`DECA_GPIO_W-1:0] gpio_b_oe_o,
  input  logic                    key_i,
  input  logic                    sw0_i,
  input  logic                    sw1_i,
  output logic [`DECA_LED_W-1:0]  leds_o,
  output logic                    irq_o,
  output logic                    timer_irq_o
);

  logic [`DECA_SWITCH_N-1:0] board_pending;

  wb_slave_if gpio_a_bus ();
  wb_slave_if gpio_b_bus ();
  wb_slave_if board_bus ();
  wb_slave_if timer_bus ();
  wb_slave_if ictrl_bus ();

  wb_address_decoder decoder_inst (
    .wb_clk   (wb_clk),
    .reset_i  (reset_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .gpio_a   (gpio_a_bus),
    .gpio_b   (gpio_b_bus),
    .board    (board_bus),
    .timer    (timer_bus),
    .ictrl    (ictrl_bus)
  );

  gpio_port gpio_a_inst (
    .wb_clk    (wb_clk),
    .reset_i   (reset_i),
    .bus       (gpio_a_bus),
    .gpio_i    (gpio_a_i),
    .gpio_o    (gpio_a_o),
    .gpio_oe_o (gpio_a_oe_o)
  );

  gpio_port gpio_b_inst (
    .wb_clk    (wb_clk),
    .reset_i   (reset_i),
    .bus       (gpio_b_bus),
    .gpio_i    (gpio_b_i),
    .gpio_o    (gpio_b_o),
    .gpio_oe_o (gpio_b_oe_o)
  );

  board_io board_inst (
    .wb_clk    (wb_clk),
    .reset_i   (reset_i),
    .bus       (board_bus),
    .key_i     (key_i),
    .sw0_i     (sw0_i),
    .sw1_i     (sw1_i),
    .leds_o    (leds_o),
    .pending_o (board_pending)
  );

  interrupt_controller ictrl_inst (
    .wb_clk  (wb_clk),
    .reset_i (reset_i),
    .bus     (ictrl_bus),
    .src_i   (board_pending),
    .irq_o   (irq_o)
  );

  machine_timer timer_inst (
    .wb_clk  (wb_clk),
    .reset_i (reset_i),
    .bus     (timer_bus),
    .irq_o   (timer_irq_o)
  );

endmodule

`default_nettype wire

// File: logic/gpio_port.sv
/*
  one 8-bit GPIO port, output and direction registers
  data reads return the live input pins, not the output register
  the pins are sampled without synchronizer
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module gpio_port (
  input  logic                    wb_clk,
  input  logic                    reset_i,
  wb_slave_if.slave               bus,
  input  logic [`DECA_GPIO_W-1:0] gpio_i,
  output logic [`DECA_GPIO_W-1:0] gpio_o,
  output logic [`DECA_GPIO_W-1:0] gpio_oe_o
);

  logic ack_q;
  logic wr;

  // write lands on the edge that raises ack
  assign wr = bus.stb && bus.we && !ack_q;

  always_ff @(posedge wb_clk) begin
    if (reset_i) begin
      ack_q     <= 1'b0;
      gpio_o    <= '0;
      gpio_oe_o <= '0;
    end else begin
      ack_q <= bus.stb && !ack_q;
      if (wr) begin
        case (deca_periph_pkg::gpio_reg_e'(bus.reg_adr))
          deca_periph_pkg::GPIO_DATA: gpio_o    <= bus.wdata[`DECA_GPIO_W-1:0];
          deca_periph_pkg::GPIO_DIR:  gpio_oe_o <= bus.wdata[`DECA_GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (deca_periph_pkg::gpio_reg_e'(bus.reg_adr))
      deca_periph_pkg::GPIO_DATA: bus.rdata[`DECA_GPIO_W-1:0] = gpio_i;
      deca_periph_pkg::GPIO_DIR:  bus.rdata[`DECA_GPIO_W-1:0] = gpio_oe_o;
      default: ;
    endcase
  end

  assign bus.ack = ack_q;

  a_ack_after_stb: assert property (@(posedge wb_clk) disable iff (reset_i)
    bus.ack |-> $past(bus.stb));

endmodule

`default_nettype wire

// File: logic/interrupt_controller.sv
/*
  enable mask over the board interrupt sources
  sources are level inputs, they are cleared at the board block
  irq_o is combinational from src_i and the mask
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module interrupt_controller (
  input  logic                      wb_clk,
  input  logic                      reset_i,
  wb_slave_if.slave                 bus,
  input  logic [`DECA_SWITCH_N-1:0] src_i,
  output logic                      irq_o
);

  logic [`DECA_SWITCH_N-1:0] enable_q;
  logic [`DECA_SWITCH_N-1:0] status;
  logic                      ack_q;
  logic                      wr;

  assign wr     = bus.stb && bus.we && !ack_q;
  assign status = src_i & enable_q;

  always_ff @(posedge wb_clk) begin
    if (reset_i) begin
      enable_q <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= bus.stb && !ack_q;
      if (wr && (bus.reg_adr == deca_periph_pkg::ICTRL_ENABLE)) begin
        enable_q <= bus.wdata[`DECA_SWITCH_N-1:0];
      end
    end
  end

  // status is read only
  always_comb begin
    bus.rdata = '0;
    case (deca_periph_pkg::ictrl_reg_e'(bus.reg_adr))
      deca_periph_pkg::ICTRL_STATUS: bus.rdata[`DECA_SWITCH_N-1:0] = status;
      deca_periph_pkg::ICTRL_ENABLE: bus.rdata[`DECA_SWITCH_N-1:0] = enable_q;
      default: ;
    endcase
  end

  assign irq_o   = |status;
  assign bus.ack = ack_q;

endmodule

`default_nettype wire

// File: logic/machine_timer.sv
/*
  RISC-V style mtime and mtimecmp, no prescaler, counts every wb_clk
  halves are not written atomically, software must handle the carry
  mtimecmp resets to all ones so the interrupt starts low
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module machine_timer (
  input  logic      wb_clk,
  input  logic      reset_i,
  wb_slave_if.slave bus,
  output logic      irq_o
);

  localparam int HALF_W = `DECA_DATA_W;

  logic [2*HALF_W-1:0] mtime_q;
  logic [2*HALF_W-1:0] mtime_next;
  logic [2*HALF_W-1:0] mtimecmp_q;
  logic                ack_q;
  logic                wr;

  assign wr = bus.stb && bus.we && !ack_q;

  // written half replaces the count, the other half keeps counting
  always_comb begin
    mtime_next = mtime_q + 1'b1;
    if (wr) begin
      case (deca_periph_pkg::timer_reg_e'(bus.reg_adr))
        deca_periph_pkg::MTIME_LO: mtime_next[HALF_W-1:0]        = bus.wdata;
        deca_periph_pkg::MTIME_HI: mtime_next[2*HALF_W-1:HALF_W] = bus.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge wb_clk) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      ack_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_next;
      ack_q   <= bus.stb && !ack_q;
      if (wr) begin
        case (deca_periph_pkg::timer_reg_e'(bus.reg_adr))
          deca_periph_pkg::MTIMECMP_LO: mtimecmp_q[HALF_W-1:0]        <= bus.wdata;
          deca_periph_pkg::MTIMECMP_HI: mtimecmp_q[2*HALF_W-1:HALF_W] <= bus.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (deca_periph_pkg::timer_reg_e'(bus.reg_adr))
      deca_periph_pkg::MTIME_LO:    bus.rdata = mtime_q[HALF_W-1:0];
      deca_periph_pkg::MTIME_HI:    bus.rdata = mtime_q[2*HALF_W-1:HALF_W];
      deca_periph_pkg::MTIMECMP_LO: bus.rdata = mtimecmp_q[HALF_W-1:0];
      deca_periph_pkg::MTIMECMP_HI: bus.rdata = mtimecmp_q[2*HALF_W-1:HALF_W];
      default:                      bus.rdata = '0;
    endcase
  end

  assign irq_o   = (mtime_q >= mtimecmp_q);
  assign bus.ack = ack_q;

  // a disarmed compare must never fire
  a_disarmed_quiet: assert property (@(posedge wb_clk) disable iff (reset_i)
    (&mtimecmp_q) |-> !irq_o);

endmodule

`default_nettype wire

// File: logic/wb_address_decoder.sv
/*
  single-master decoder, region field in address bits 11..8
  master must hold the request until ack or err, then drop stb a cycle
  unmapped regions get err one cycle after the request, read data zero
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module wb_address_decoder (
  input  logic                    wb_clk,
  input  logic                    reset_i,
  input  logic [`DECA_ADDR_W-1:0] wb_adr_i,
  input  deca_periph_pkg::word_t  wb_dat_i,
  input  logic                    wb_we_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  output deca_periph_pkg::word_t  wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  wb_slave_if.decoder             gpio_a,
  wb_slave_if.decoder             gpio_b,
  wb_slave_if.decoder             board,
  wb_slave_if.decoder             timer,
  wb_slave_if.decoder             ictrl
);

  deca_periph_pkg::region_e region;
  logic [`DECA_REG_W-1:0]   reg_adr;
  logic                     req;
  logic                     mapped;
  logic                     err_q;

  assign region  = deca_periph_pkg::region_e'(wb_adr_i[`DECA_REGION_LSB +: `DECA_REGION_W]);
  assign reg_adr = wb_adr_i[`DECA_REG_LSB +: `DECA_REG_W];
  assign req     = wb_cyc_i && wb_stb_i;

  // strobe only the matching slave
  assign gpio_a.stb = req && (region == deca_periph_pkg::REGION_GPIO_A);
  assign gpio_b.stb = req && (region == deca_periph_pkg::REGION_GPIO_B);
  assign board.stb  = req && (region == deca_periph_pkg::REGION_BOARD);
  assign timer.stb  = req && (region == deca_periph_pkg::REGION_TIMER);
  assign ictrl.stb  = req && (region == deca_periph_pkg::REGION_ICTRL);

  // the rest fans out unchanged
  assign gpio_a.we      = wb_we_i;
  assign gpio_b.we      = wb_we_i;
  assign board.we       = wb_we_i;
  assign timer.we       = wb_we_i;
  assign ictrl.we       = wb_we_i;
  assign gpio_a.reg_adr = reg_adr;
  assign gpio_b.reg_adr = reg_adr;
  assign board.reg_adr  = reg_adr;
  assign timer.reg_adr  = reg_adr;
  assign ictrl.reg_adr  = reg_adr;
  assign gpio_a.wdata   = wb_dat_i;
  assign gpio_b.wdata   = wb_dat_i;
  assign board.wdata    = wb_dat_i;
  assign timer.wdata    = wb_dat_i;
  assign ictrl.wdata    = wb_dat_i;

  // read mux, address is held through the ack cycle
  always_comb begin
    mapped = 1'b1;
    case (region)
      deca_periph_pkg::REGION_GPIO_A: wb_dat_o = gpio_a.rdata;
      deca_periph_pkg::REGION_GPIO_B: wb_dat_o = gpio_b.rdata;
      deca_periph_pkg::REGION_BOARD:  wb_dat_o = board.rdata;
      deca_periph_pkg::REGION_TIMER:  wb_dat_o = timer.rdata;
      deca_periph_pkg::REGION_ICTRL:  wb_dat_o = ictrl.rdata;
      default: begin
        wb_dat_o = '0;
        mapped   = 1'b0;
      end
    endcase
  end

  // one-cycle error pulse for holes in the map
  always_ff @(posedge wb_clk) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && !mapped && !err_q;
    end
  end

  assign wb_err_o = err_q;
  assign wb_ack_o = gpio_a.ack | gpio_b.ack | board.ack | timer.ack | ictrl.ack;

  a_single_stb: assert property (@(posedge wb_clk) disable iff (reset_i)
    $onehot0({gpio_a.stb, gpio_b.stb, board.stb, timer.stb, ictrl.stb}));

  a_err_not_ack: assert property (@(posedge wb_clk) disable iff (reset_i)
    !(wb_err_o && wb_ack_o));

endmodule

`default_nettype wire

// File: logic/wb_slave_if.sv
/*
  link from the address decoder to one slave
  stb is already qualified by cyc and the region match
  slaves answer with a single-cycle ack, there is no err or stall here
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

interface wb_slave_if;

  logic                    stb;
  logic                    we;
  logic [`DECA_REG_W-1:0]  reg_adr;
  deca_periph_pkg::word_t  wdata;
  deca_periph_pkg::word_t  rdata;
  logic                    ack;

  modport decoder (
    output stb,
    output we,
    output reg_adr,
    output wdata,
    input  rdata,
    input  ack
  );

  modport slave (
    input  stb,
    input  we,
    input  reg_adr,
    input  wdata,
    output rdata,
    output ack
  );

endinterface

`default_nettype wire

// File: tb/deca_periph_tb.sv
/*
  self-checking testbench for the board peripheral block
  one Wishbone request at a time, inputs change on the falling edge
  pending bits are modeled from the driven switch pins
  mtime is modeled as the clock edges counted since reset
*/
`timescale 1ns/1ps
`default_nettype none

`include "deca_periph_config.svh"

module deca_periph_tb;

  localparam int CLK_PERIOD_NS = 4;
  localparam int ACK_LIMIT     = 4;
  localparam int TXN_COUNT     = 160;
  localparam int WATCHDOG_NS   = TXN_COUNT * 10 * CLK_PERIOD_NS + 2000;
  localparam bit KIND_IDLE     = 1'b0;
  localparam bit KIND_BUS      = 1'b1;

  logic                      wb_clk;
  logic                      reset_i;
  logic [`DECA_ADDR_W-1:0]   wb_adr_i;
  deca_periph_pkg::word_t    wb_dat_i;
  logic                      wb_we_i;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  deca_periph_pkg::word_t    wb_dat_o;
  logic                      wb_ack_o;
  logic                      wb_err_o;
  logic [`DECA_GPIO_W-1:0]   gpio_a_i;
  logic [`DECA_GPIO_W-1:0]   gpio_a_o;
  logic [`DECA_GPIO_W-1:0]   gpio_a_oe_o;
  logic [`DECA_GPIO_W-1:0]   gpio_b_i;
  logic [`DECA_GPIO_W-1:0]   gpio_b_o;
  logic [`DECA_GPIO_W-1:0]   gpio_b_oe_o;
  logic                      key_i;
  logic                      sw0_i;
  logic                      sw1_i;
  logic [`DECA_LED_W-1:0]    leds_o;
  logic                      irq_o;
  logic                      timer_irq_o;

  // shadow copy of what the DUT should hold
  logic [`DECA_GPIO_W-1:0]   gpio_out_sh [2];
  logic [`DECA_GPIO_W-1:0]   gpio_dir_sh [2];
  logic [`DECA_GPIO_W-1:0]   gpio_pin_sh [2];
  logic [`DECA_LED_W-1:0]    leds_sh;
  logic [`DECA_SWITCH_N-1:0] pins_sh;
  logic [`DECA_SWITCH_N-1:0] pending_sh;
  logic [`DECA_SWITCH_N-1:0] enable_sh;
  logic [63:0]               cmp_sh;
  logic [63:0]               mtime_sh;
  deca_periph_pkg::word_t    last_mtime_lo;
  logic [31:0]               rng_state;

  // one finished request, handed to the compare process
  logic                      check_pending;
  logic                      check_kind;
  logic                      seen_write;
  logic [`DECA_REGION_W-1:0] seen_region;
  logic [`DECA_REG_W-1:0]    seen_offset;
  deca_periph_pkg::word_t    seen_data;
  logic                      seen_ack;
  logic                      seen_err;

  deca_periph_top deca_periph_top_inst (
    .wb_clk      (wb_clk),
    .reset_i     (reset_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .gpio_a_i    (gpio_a_i),
    .gpio_a_o    (gpio_a_o),
    .gpio_a_oe_o (gpio_a_oe_o),
    .gpio_b_i    (gpio_b_i),
    .gpio_b_o    (gpio_b_o),
    .gpio_b_oe_o (gpio_b_oe_o),
    .key_i       (key_i),
    .sw0_i       (sw0_i),
    .sw1_i       (sw1_i),
    .leds_o      (leds_o),
    .irq_o       (irq_o),
    .timer_irq_o (timer_irq_o)
  );

  always #(CLK_PERIOD_NS / 2) wb_clk = ~wb_clk;

  // mtime model, one count per clock edge out of reset
  always @(posedge wb_clk) begin
    if (reset_i) begin
      mtime_sh <= '0;
    end else begin
      mtime_sh <= mtime_sh + 64'd1;
    end
  end

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL at %0d ns: %s got %h expected %h", $time, what, got, expected);
      fail_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] random_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`DECA_ADDR_W-1:0] reg_address(input logic [`DECA_REGION_W-1:0] region,
                                                          input logic [`DECA_REG_W-1:0] offset);
    logic [`DECA_ADDR_W-1:0] addr;
    addr = '0;
    addr[`DECA_REGION_LSB +: `DECA_REGION_W] = region;
    addr[`DECA_REG_LSB +: `DECA_REG_W]       = offset;
    return addr;
  endfunction

  // reference register file, read side
  function automatic deca_periph_pkg::word_t expected_read(
      input logic [`DECA_REGION_W-1:0] region, input logic [`DECA_REG_W-1:0] offset);
    deca_periph_pkg::word_t value;
    value = '0;
    case (region)
      deca_periph_pkg::REGION_GPIO_A, deca_periph_pkg::REGION_GPIO_B: begin
        if (offset == deca_periph_pkg::GPIO_DATA) value[`DECA_GPIO_W-1:0] = gpio_pin_sh[region[0]];
        if (offset == deca_periph_pkg::GPIO_DIR)  value[`DECA_GPIO_W-1:0] = gpio_dir_sh[region[0]];
      end
      deca_periph_pkg::REGION_BOARD: begin
        if (offset == deca_periph_pkg::BOARD_SWITCH)  value[`DECA_SWITCH_N-1:0] = pins_sh;
        if (offset == deca_periph_pkg::BOARD_PENDING) value[`DECA_SWITCH_N-1:0] = pending_sh;
        if (offset == deca_periph_pkg::BOARD_LEDS)    value[`DECA_LED_W-1:0]    = leds_sh;
      end
      deca_periph_pkg::REGION_TIMER: begin
        if (offset == deca_periph_pkg::MTIMECMP_LO) value = cmp_sh[31:0];
        if (offset == deca_periph_pkg::MTIMECMP_HI) value = cmp_sh[63:32];
      end
      deca_periph_pkg::REGION_ICTRL: begin
        if (offset == deca_periph_pkg::ICTRL_STATUS) value[`DECA_SWITCH_N-1:0] = pending_sh & enable_sh;
        if (offset == deca_periph_pkg::ICTRL_ENABLE) value[`DECA_SWITCH_N-1:0] = enable_sh;
      end
      default: value = '0;
    endcase
    return value;
  endfunction

  // reference register file, write side
  function automatic void apply_write(input logic [`DECA_REGION_W-1:0] region,
                                      input logic [`DECA_REG_W-1:0] offset,
                                      input deca_periph_pkg::word_t data);
    case (region)
      deca_periph_pkg::REGION_GPIO_A, deca_periph_pkg::REGION_GPIO_B: begin
        if (offset == deca_periph_pkg::GPIO_DATA) gpio_out_sh[region[0]] = data[`DECA_GPIO_W-1:0];
        if (offset == deca_periph_pkg::GPIO_DIR)  gpio_dir_sh[region[0]] = data[`DECA_GPIO_W-1:0];
      end
      deca_periph_pkg::REGION_BOARD: begin
        if (offset == deca_periph_pkg::BOARD_PENDING) pending_sh = pending_sh & ~data[`DECA_SWITCH_N-1:0];
        if (offset == deca_periph_pkg::BOARD_LEDS)    leds_sh = data[`DECA_LED_W-1:0];
      end
      deca_periph_pkg::REGION_TIMER: begin
        if (offset == deca_periph_pkg::MTIMECMP_LO) cmp_sh[31:0]  = data;
        if (offset == deca_periph_pkg::MTIMECMP_HI) cmp_sh[63:32] = data;
      end
      deca_periph_pkg::REGION_ICTRL: begin
        if (offset == deca_periph_pkg::ICTRL_ENABLE) enable_sh = data[`DECA_SWITCH_N-1:0];
      end
      default: ;
    endcase
  endfunction

  // hand over to the compare process and wait until it is done
  task automatic request_check(input logic kind);
    check_kind    = kind;
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  task automatic bus_cycle(input logic write, input logic [`DECA_REGION_W-1:0] region,
                           input logic [`DECA_REG_W-1:0] offset, input deca_periph_pkg::word_t data);
    int waited;
    waited = 0;
    @(negedge wb_clk);
    wb_adr_i = reg_address(region, offset);
    wb_dat_i = data;
    wb_we_i  = write;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do begin
      @(negedge wb_clk);
      waited++;
    end while (!wb_ack_o && !wb_err_o && waited < ACK_LIMIT);
    if (!wb_ack_o && !wb_err_o) begin
      $display("bus request to region %0d offset %0d got neither ack nor err", region, offset);
      fail_run();
    end
    seen_write  = write;
    seen_region = region;
    seen_offset = offset;
    seen_data   = wb_dat_o;
    seen_ack    = wb_ack_o;
    seen_err    = wb_err_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (write && region <= deca_periph_pkg::REGION_ICTRL) apply_write(region, offset, data);
    request_check(KIND_BUS);
  endtask

  task automatic write_reg(input logic [`DECA_REGION_W-1:0] region,
                           input logic [`DECA_REG_W-1:0] offset, input deca_periph_pkg::word_t data);
    bus_cycle(1'b1, region, offset, data);
  endtask

  task automatic read_reg(input logic [`DECA_REGION_W-1:0] region,
                          input logic [`DECA_REG_W-1:0] offset);
    bus_cycle(1'b0, region, offset, '0);
  endtask

  task automatic drive_gpio_pins(input int port, input logic [`DECA_GPIO_W-1:0] value);
    @(negedge wb_clk);
    if (port == 0) gpio_a_i = value;
    else gpio_b_i = value;
    gpio_pin_sh[port] = value;
  endtask

  // pins are {sw1, sw0, key}, wait out the synchronizer
  task automatic drive_switches(input logic [`DECA_SWITCH_N-1:0] pins);
    @(negedge wb_clk);
    {sw1_i, sw0_i, key_i} = pins;
    pending_sh = pending_sh | (pins ^ pins_sh);
    pins_sh    = pins;
    repeat (`DECA_SYNC_STAGES + 2) @(negedge wb_clk);
  endtask

  // compare process
  always begin
    wait (check_pending);
    if (check_kind == KIND_IDLE) begin
      check_value("idle ack", 32'(wb_ack_o), 32'd0);
      check_value("idle err", 32'(wb_err_o), 32'd0);
    end else if (seen_region <= deca_periph_pkg::REGION_ICTRL) begin
      check_value("ack on mapped region", 32'(seen_ack), 32'd1);
      check_value("err on mapped region", 32'(seen_err), 32'd0);
      if (!seen_write && seen_region == deca_periph_pkg::REGION_TIMER &&
          seen_offset == deca_periph_pkg::MTIME_LO) begin
        check_value("mtime rising", 32'(seen_data > last_mtime_lo), 32'd1);
        last_mtime_lo = seen_data;
      end else if (!seen_write) begin
        check_value($sformatf("read region %0d offset %0d", seen_region, seen_offset),
                    seen_data, expected_read(seen_region, seen_offset));
      end
    end else begin
      check_value("ack on unmapped region", 32'(seen_ack), 32'd0);
      check_value("err on unmapped region", 32'(seen_err), 32'd1);
      check_value("rdata on unmapped region", seen_data, 32'd0);
    end
    check_value("gpio_a_o", 32'(gpio_a_o), 32'(gpio_out_sh[0]));
    check_value("gpio_a_oe_o", 32'(gpio_a_oe_o), 32'(gpio_dir_sh[0]));
    check_value("gpio_b_o", 32'(gpio_b_o), 32'(gpio_out_sh[1]));
    check_value("gpio_b_oe_o", 32'(gpio_b_oe_o), 32'(gpio_dir_sh[1]));
    check_value("leds_o", 32'(leds_o), 32'(leds_sh));
    check_value("irq_o", 32'(irq_o), 32'(|(pending_sh & enable_sh)));
    check_value("timer_irq_o", 32'(timer_irq_o), 32'(mtime_sh >= cmp_sh));
    check_pending = 1'b0;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
    fail_run();
  end

  initial begin
    logic [31:0] value;
    logic [`DECA_REGION_W-1:0] region;
    wb_clk = 1'b0;
    reset_i = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_we_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    gpio_a_i = '0;
    gpio_b_i = '0;
    {sw1_i, sw0_i, key_i} = '0;
    gpio_out_sh = '{default: '0};
    gpio_dir_sh = '{default: '0};
    gpio_pin_sh = '{default: '0};
    leds_sh = '0;
    pins_sh = '0;
    pending_sh = '0;
    enable_sh = '0;
    cmp_sh = '1;
    last_mtime_lo = '0;
    rng_state = 32'hb40e;
    check_pending = 1'b0;
    repeat (3) @(posedge wb_clk);
    @(negedge wb_clk);
    reset_i = 1'b0;
    request_check(KIND_IDLE);

    // GPIO data, direction and live pins on both ports
    for (int round = 0; round < 6; round++) begin
      for (int port = 0; port < 2; port++) begin
        region = (port == 0) ? deca_periph_pkg::REGION_GPIO_A : deca_periph_pkg::REGION_GPIO_B;
        write_reg(region, deca_periph_pkg::GPIO_DATA, random_word());
        write_reg(region, deca_periph_pkg::GPIO_DIR, random_word());
        read_reg(region, deca_periph_pkg::GPIO_DIR);
        value = random_word();
        drive_gpio_pins(port, value[`DECA_GPIO_W-1:0]);
        read_reg(region, deca_periph_pkg::GPIO_DATA);
      end
    end

    // holes in the map, then the LED register
    for (int r = 5; r < 16; r++) begin
      write_reg(4'(r), 3'd0, random_word());
      read_reg(4'(r), 3'(r % 8));
    end
    for (int round = 0; round < 4; round++) begin
      write_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_LEDS, random_word());
      read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_LEDS);
    end

    // switch changes, enables and write-1 clear
    drive_switches(3'b101);
    read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_SWITCH);
    read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_PENDING);
    write_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_ENABLE, 32'h1);
    read_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_STATUS);
    write_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_ENABLE, 32'h2);
    write_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_ENABLE, 32'h7);
    read_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_ENABLE);
    write_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_PENDING, 32'h5);
    read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_PENDING);
    for (int round = 0; round < 4; round++) begin
      value = random_word();
      drive_switches(value[`DECA_SWITCH_N-1:0]);
      read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_SWITCH);
      read_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_PENDING);
      read_reg(deca_periph_pkg::REGION_ICTRL, deca_periph_pkg::ICTRL_STATUS);
      write_reg(deca_periph_pkg::REGION_BOARD, deca_periph_pkg::BOARD_PENDING, 32'h7);
    end

    // timer, compare far above mtime and then at zero
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIME_LO);
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIME_LO);
    write_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_HI, 32'h1);
    write_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_LO, 32'h0);
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_LO);
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_HI);
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIME_LO);
    write_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_HI, 32'h0);
    read_reg(deca_periph_pkg::REGION_TIMER, deca_periph_pkg::MTIMECMP_HI);
    @(negedge wb_clk);
    request_check(KIND_IDLE);

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
logic/deca_periph_pkg.sv
logic/wb_slave_if.sv
logic/wb_address_decoder.sv
logic/gpio_port.sv
logic/board_io.sv
logic/interrupt_controller.sv
logic/machine_timer.sv
logic/deca_periph_top.sv
tb/deca_periph_tb.sv
